// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width
`define XLEN 32

// destination register address width
`define REG_ADDR_W 6

// data memory size in words and word index width
`define DMEM_WORDS 256
`define DMEM_AW 8

`endif

// File: src/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	// writeback source select
	typedef enum logic [2:0] {
		SEL_ALU = 3'd0,
		SEL_MEM = 3'd1,
		SEL_CSR = 3'd2,
		SEL_PC4 = 3'd3
	} wb_src_t;

	// memory operation whose direction comes from rd_wena
	typedef enum logic [2:0] {
		MEM_LB  = 3'd0,
		MEM_LH  = 3'd1,
		MEM_LW  = 3'd2,
		MEM_LBU = 3'd3,
		MEM_LHU = 3'd4,
		MEM_SB  = 3'd5,
		MEM_SH  = 3'd6,
		MEM_SW  = 3'd7
	} mem_op_t;

endpackage

// File: src/dmem_bus_pkg.sv
package dmem_bus_pkg;

	// response codes of the data-memory bus
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} bus_resp_t;

endpackage

// File: src/dmem_request.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module dmem_request (
	input	logic				valid_in,
	input	cpu_pipe_pkg::wb_src_t	wb_src_ex,
	input	cpu_pipe_pkg::mem_op_t	mem_op_ex,
	input	logic				rd_wena_ex,
	input	logic	[`XLEN-1:0]	rd_data_ex,
	input	logic	[`XLEN-1:0]	store_data_ex,

	output	logic				arvalid,
	output	logic	[`XLEN-1:0]	araddr,
	output	logic				awvalid,
	output	logic	[`XLEN-1:0]	awaddr,
	output	logic				wvalid,
	output	logic	[`XLEN-1:0]	wdata,
	output	logic	[3:0]		wstrb,

	output	logic				maligned_load,
	output	logic				maligned_store
);

	import cpu_pipe_pkg::*;

	logic			mem_access;
	logic			req;
	logic	[1:0]	byte_off;
	logic			size_byte;
	logic			size_half;
	logic			misaligned;
	logic	[3:0]	lane_mask;

	assign mem_access	= (wb_src_ex == SEL_MEM);
	assign req			= valid_in && mem_access;
	assign byte_off		= rd_data_ex[1:0];

	always_comb begin
		size_byte	= 1'b0;
		size_half	= 1'b0;
		case (mem_op_ex)
		MEM_LB, MEM_LBU, MEM_SB:	size_byte = 1'b1;
		MEM_LH, MEM_LHU, MEM_SH:	size_half = 1'b1;
		default:					size_byte = 1'b0;	// word access
		endcase
	end

	// halfwords on even bytes and words on word boundaries
	assign misaligned	= (size_half && byte_off[0]) ||
						  (!size_byte && !size_half && byte_off != 2'b00);

	always_comb begin
		if (size_byte)
			lane_mask = 4'b0001;
		else if (size_half)
			lane_mask = 4'b0011;
		else
			lane_mask = 4'b1111;
	end

	assign maligned_load	= mem_access && rd_wena_ex && misaligned;
	assign maligned_store	= mem_access && !rd_wena_ex && misaligned;

	assign arvalid	= req && rd_wena_ex;
	assign araddr	= rd_data_ex;

	assign awvalid	= req && !rd_wena_ex;
	assign wvalid	= req && !rd_wena_ex;
	assign awaddr	= rd_data_ex;
	assign wdata	= store_data_ex << {byte_off, 3'b000};	// move into addressed lanes
	assign wstrb	= misaligned ? 4'b0000 : (lane_mask << byte_off);

endmodule

// File: src/dmem_ram.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module dmem_ram (
	input	logic						clk,
	input	logic						reset,

	input	logic						arvalid,
	input	logic	[`XLEN-1:0]			araddr,
	output	logic						rvalid,
	output	logic	[`XLEN-1:0]			rdata,
	output	dmem_bus_pkg::bus_resp_t	rresp,
	input	logic						rready,

	input	logic						awvalid,
	input	logic	[`XLEN-1:0]			awaddr,
	input	logic						wvalid,
	input	logic	[`XLEN-1:0]			wdata,
	input	logic	[3:0]				wstrb,
	output	logic						bvalid,
	output	dmem_bus_pkg::bus_resp_t	bresp,
	input	logic						bready
);

	import dmem_bus_pkg::*;

	logic	[`XLEN-1:0]		mem	[`DMEM_WORDS];
	logic					busy;
	logic					rd_accept;
	logic					wr_accept;
	logic					rd_in_range;
	logic					wr_in_range;

	assign busy			= rvalid || bvalid;	// one request outstanding at most
	assign rd_accept	= arvalid && !busy;
	assign wr_accept	= awvalid && wvalid && !busy && !arvalid;
	assign rd_in_range	= (araddr[`XLEN-1:`DMEM_AW+2] == '0);
	assign wr_in_range	= (awaddr[`XLEN-1:`DMEM_AW+2] == '0);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rvalid	<= 1'b0;
			rresp	<= RESP_OKAY;
			bvalid	<= 1'b0;
			bresp	<= RESP_OKAY;
		end else begin
			if (rd_accept) begin
				rvalid	<= 1'b1;
				rresp	<= rd_in_range ? RESP_OKAY : RESP_SLVERR;
			end else if (rvalid && rready) begin
				rvalid	<= 1'b0;
			end

			if (wr_accept) begin
				bvalid	<= 1'b1;
				bresp	<= wr_in_range ? RESP_OKAY : RESP_SLVERR;
			end else if (bvalid && bready) begin
				bvalid	<= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept)
			rdata <= rd_in_range ? mem[araddr[`DMEM_AW+1:2]] : '0;
		if (wr_accept && wr_in_range) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i])
					mem[awaddr[`DMEM_AW+1:2]][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mem_stage (
	input	logic						clk,
	input	logic						reset,

	input	logic						valid_in,
	output	logic						ready_out,
	input	logic						flush_in,
	output	logic						flush_out,
	output	logic						valid_out,
	input	logic						ready_in,

	input	logic						rvalid,
	input	logic	[`XLEN-1:0]			rdata,
	input	dmem_bus_pkg::bus_resp_t	rresp,
	output	logic						rready,
	input	logic						bvalid,
	input	dmem_bus_pkg::bus_resp_t	bresp,
	output	logic						bready,
	input	logic	[`XLEN-1:0]			araddr,
	input	logic						maligned_load,
	input	logic						maligned_store,

	input	logic	[`XLEN-1:0]			pc_ex,
	input	logic	[`XLEN-1:0]			ir_ex,
	input	logic						rd_wena_ex,
	input	logic	[`REG_ADDR_W-1:0]	rd_addr_ex,
	input	logic	[`XLEN-1:0]			rd_data_ex,
	input	logic						csr_wena_ex,
	input	logic	[`XLEN-1:0]			csr_wdata_ex,
	input	cpu_pipe_pkg::wb_src_t		wb_src_ex,
	input	cpu_pipe_pkg::mem_op_t		mem_op_ex,

	output	logic	[`XLEN-1:0]			pc_mem,
	output	logic	[`XLEN-1:0]			ir_mem,
	output	logic						rd_wena_mem,
	output	logic	[`REG_ADDR_W-1:0]	rd_addr_mem,
	output	logic	[`XLEN-1:0]			rd_data_mem,
	output	logic						csr_wena_mem,
	output	logic	[`XLEN-1:0]			csr_wdata_mem,
	output	cpu_pipe_pkg::wb_src_t		wb_src_mem,
	output	logic						maligned_load_mem,
	output	logic						maligned_store_mem,
	output	dmem_bus_pkg::bus_resp_t	rresp_mem,
	output	dmem_bus_pkg::bus_resp_t	bresp_mem
);

	import cpu_pipe_pkg::*;
	import dmem_bus_pkg::*;

	logic				stall;
	logic	[`XLEN-1:0]	rdata_aligned;

	assign rdata_aligned	= rdata >> {araddr[1:0], 3'b000};	// addressed byte to lane 0

	assign rready		= ready_in;
	assign bready		= ready_in;
	assign flush_out	= flush_in;

	// hold behind a pending csr write or a missing bus response
	assign stall		= csr_wena_mem || (wb_src_ex == SEL_MEM &&
						  ((rd_wena_ex && !rvalid) || (!rd_wena_ex && !bvalid)));
	assign ready_out	= ready_in && !stall;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out			<= 1'b0;
			pc_mem				<= '0;
			ir_mem				<= '0;
			rd_wena_mem			<= 1'b0;
			rd_addr_mem			<= '0;
			rd_data_mem			<= '0;
			csr_wena_mem		<= 1'b0;
			csr_wdata_mem		<= '0;
			wb_src_mem			<= SEL_ALU;
			maligned_load_mem	<= 1'b0;
			maligned_store_mem	<= 1'b0;
			rresp_mem			<= RESP_OKAY;
			bresp_mem			<= RESP_OKAY;
		end else if (valid_in && ready_out) begin
			valid_out			<= 1'b1;
			pc_mem				<= pc_ex;
			ir_mem				<= ir_ex;
			rd_wena_mem			<= rd_wena_ex;
			rd_addr_mem			<= rd_addr_ex;
			rd_data_mem			<= rd_data_ex;
			csr_wena_mem		<= csr_wena_ex;
			csr_wdata_mem		<= csr_wdata_ex;
			wb_src_mem			<= wb_src_ex;
			maligned_load_mem	<= maligned_load;
			maligned_store_mem	<= maligned_store;
			rresp_mem			<= RESP_OKAY;
			bresp_mem			<= RESP_OKAY;

			if (wb_src_ex == SEL_MEM) begin
				if (rd_wena_ex) begin	// load
					case (mem_op_ex)
					MEM_LB:		rd_data_mem <= {{24{rdata_aligned[7]}}, rdata_aligned[7:0]};
					MEM_LBU:	rd_data_mem <= {24'h000000, rdata_aligned[7:0]};
					MEM_LH:		rd_data_mem <= {{16{rdata_aligned[15]}}, rdata_aligned[15:0]};
					MEM_LHU:	rd_data_mem <= {16'h0000, rdata_aligned[15:0]};
					default:	rd_data_mem <= rdata_aligned;
					endcase
					rresp_mem	<= rresp;
				end else begin	// store
					rd_data_mem	<= '0;
					bresp_mem	<= bresp;
				end
			end
		end else if (valid_out && ready_in) begin
			valid_out			<= 1'b0;
			pc_mem				<= '0;
			ir_mem				<= '0;
			rd_wena_mem			<= 1'b0;
			rd_addr_mem			<= '0;
			rd_data_mem			<= '0;
			csr_wena_mem		<= 1'b0;
			csr_wdata_mem		<= '0;
			wb_src_mem			<= SEL_ALU;
			maligned_load_mem	<= 1'b0;
			maligned_store_mem	<= 1'b0;
			rresp_mem			<= RESP_OKAY;
			bresp_mem			<= RESP_OKAY;
		end
	end

endmodule

// File: src/mem_subsystem_top.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mem_subsystem_top (
	input	logic						clk,
	input	logic						reset,

	input	logic						valid_in,
	output	logic						ready_out,
	input	logic						flush_in,
	input	logic	[`XLEN-1:0]			pc_ex,
	input	logic	[`XLEN-1:0]			ir_ex,
	input	logic						rd_wena_ex,
	input	logic	[`REG_ADDR_W-1:0]	rd_addr_ex,
	input	logic	[`XLEN-1:0]			rd_data_ex,
	input	logic	[`XLEN-1:0]			store_data_ex,
	input	cpu_pipe_pkg::wb_src_t		wb_src_ex,
	input	cpu_pipe_pkg::mem_op_t		mem_op_ex,
	input	logic						csr_wena_ex,
	input	logic	[`XLEN-1:0]			csr_wdata_ex,

	output	logic						valid_out,
	input	logic						ready_in,
	output	logic						flush_out,
	output	logic	[`XLEN-1:0]			pc_mem,
	output	logic	[`XLEN-1:0]			ir_mem,
	output	logic						rd_wena_mem,
	output	logic	[`REG_ADDR_W-1:0]	rd_addr_mem,
	output	logic	[`XLEN-1:0]			rd_data_mem,
	output	logic						csr_wena_mem,
	output	logic	[`XLEN-1:0]			csr_wdata_mem,
	output	cpu_pipe_pkg::wb_src_t		wb_src_mem,
	output	logic						maligned_load_mem,
	output	logic						maligned_store_mem,
	output	dmem_bus_pkg::bus_resp_t	rresp_mem,
	output	dmem_bus_pkg::bus_resp_t	bresp_mem
);

	import dmem_bus_pkg::*;

	logic				arvalid;
	logic	[`XLEN-1:0]	araddr;
	logic				awvalid;
	logic	[`XLEN-1:0]	awaddr;
	logic				wvalid;
	logic	[`XLEN-1:0]	wdata;
	logic	[3:0]		wstrb;
	logic				rvalid;
	logic	[`XLEN-1:0]	rdata;
	bus_resp_t			rresp;
	logic				rready;
	logic				bvalid;
	bus_resp_t			bresp;
	logic				bready;
	logic				maligned_load;
	logic				maligned_store;

	dmem_request dmem_request_inst (
		.valid_in		(valid_in),
		.wb_src_ex		(wb_src_ex),
		.mem_op_ex		(mem_op_ex),
		.rd_wena_ex		(rd_wena_ex),
		.rd_data_ex		(rd_data_ex),
		.store_data_ex	(store_data_ex),
		.arvalid		(arvalid),
		.araddr			(araddr),
		.awvalid		(awvalid),
		.awaddr			(awaddr),
		.wvalid			(wvalid),
		.wdata			(wdata),
		.wstrb			(wstrb),
		.maligned_load	(maligned_load),
		.maligned_store	(maligned_store)
	);

	dmem_ram dmem_ram_inst (
		.clk		(clk),
		.reset		(reset),
		.arvalid	(arvalid),
		.araddr		(araddr),
		.rvalid		(rvalid),
		.rdata		(rdata),
		.rresp		(rresp),
		.rready		(rready),
		.awvalid	(awvalid),
		.awaddr		(awaddr),
		.wvalid		(wvalid),
		.wdata		(wdata),
		.wstrb		(wstrb),
		.bvalid		(bvalid),
		.bresp		(bresp),
		.bready		(bready)
	);

	mem_stage mem_stage_inst (
		.clk				(clk),
		.reset				(reset),
		.valid_in			(valid_in),
		.ready_out			(ready_out),
		.flush_in			(flush_in),
		.flush_out			(flush_out),
		.valid_out			(valid_out),
		.ready_in			(ready_in),
		.rvalid				(rvalid),
		.rdata				(rdata),
		.rresp				(rresp),
		.rready				(rready),
		.bvalid				(bvalid),
		.bresp				(bresp),
		.bready				(bready),
		.araddr				(araddr),
		.maligned_load		(maligned_load),
		.maligned_store		(maligned_store),
		.pc_ex				(pc_ex),
		.ir_ex				(ir_ex),
		.rd_wena_ex			(rd_wena_ex),
		.rd_addr_ex			(rd_addr_ex),
		.rd_data_ex			(rd_data_ex),
		.csr_wena_ex		(csr_wena_ex),
		.csr_wdata_ex		(csr_wdata_ex),
		.wb_src_ex			(wb_src_ex),
		.mem_op_ex			(mem_op_ex),
		.pc_mem				(pc_mem),
		.ir_mem				(ir_mem),
		.rd_wena_mem		(rd_wena_mem),
		.rd_addr_mem		(rd_addr_mem),
		.rd_data_mem		(rd_data_mem),
		.csr_wena_mem		(csr_wena_mem),
		.csr_wdata_mem		(csr_wdata_mem),
		.wb_src_mem			(wb_src_mem),
		.maligned_load_mem	(maligned_load_mem),
		.maligned_store_mem	(maligned_store_mem),
		.rresp_mem			(rresp_mem),
		.bresp_mem			(bresp_mem)
	);

endmodule

// File: verif/mem_stage_props.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mem_stage_props (
	input	logic						clk,
	input	logic						reset,
	input	logic						valid_out,
	input	logic						ready_in,
	input	logic						ready_out,
	input	logic						rvalid,
	input	logic						rd_wena_ex,
	input	cpu_pipe_pkg::wb_src_t		wb_src_ex,
	input	logic	[`XLEN-1:0]			pc_mem,
	input	logic	[`XLEN-1:0]			ir_mem,
	input	logic	[`REG_ADDR_W-1:0]	rd_addr_mem,
	input	logic	[`XLEN-1:0]			rd_data_mem,
	input	logic						csr_wena_mem,
	input	cpu_pipe_pkg::wb_src_t		wb_src_mem,
	input	dmem_bus_pkg::bus_resp_t	rresp_mem,
	input	dmem_bus_pkg::bus_resp_t	bresp_mem
);

	import cpu_pipe_pkg::*;

	int fail_count = 0;

	hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in |=> $stable({valid_out, pc_mem, ir_mem, rd_addr_mem,
			rd_data_mem, csr_wena_mem, wb_src_mem, rresp_mem, bresp_mem}))
	else begin
		$error("output register changed while ready_in was low");
		fail_count++;
	end

	load_waits: assert property (@(posedge clk) disable iff (reset)
		wb_src_ex == SEL_MEM && rd_wena_ex && !rvalid |-> !ready_out)
	else begin
		$error("ready_out high while a load waits for rvalid");
		fail_count++;
	end

	empty_after_reset: assert property (@(posedge clk) $fell(reset) |-> !valid_out)
	else begin
		$error("valid_out high right after reset release");
		fail_count++;
	end

endmodule

// File: verif/mem_subsystem_tb.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mem_subsystem_tb;

	import cpu_pipe_pkg::*;
	import dmem_bus_pkg::*;

	// about 70 entries of up to 4 cycles each plus reset and a wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic						clk = 1'b0;
	logic						reset;
	logic						valid_in;
	logic						ready_out;
	logic						flush_in;
	logic	[`XLEN-1:0]			pc_ex;
	logic	[`XLEN-1:0]			ir_ex;
	logic						rd_wena_ex;
	logic	[`REG_ADDR_W-1:0]	rd_addr_ex;
	logic	[`XLEN-1:0]			rd_data_ex;
	logic	[`XLEN-1:0]			store_data_ex;
	wb_src_t					wb_src_ex;
	mem_op_t					mem_op_ex;
	logic						csr_wena_ex;
	logic	[`XLEN-1:0]			csr_wdata_ex;
	logic						valid_out;
	logic						ready_in;
	logic						flush_out;
	logic	[`XLEN-1:0]			pc_mem;
	logic	[`XLEN-1:0]			ir_mem;
	logic						rd_wena_mem;
	logic	[`REG_ADDR_W-1:0]	rd_addr_mem;
	logic	[`XLEN-1:0]			rd_data_mem;
	logic						csr_wena_mem;
	logic	[`XLEN-1:0]			csr_wdata_mem;
	wb_src_t					wb_src_mem;
	logic						maligned_load_mem;
	logic						maligned_store_mem;
	bus_resp_t					rresp_mem;
	bus_resp_t					bresp_mem;

	logic	[7:0]		model_mem [`DMEM_WORDS*4];	// byte view of the data memory
	logic	[31:0]		ir_sent [256];	// ir of each entry indexed by pc
	logic	[31:0]		rng_state = 32'd93;
	logic	[31:0]		pc_tag = '0;	// pc doubles as a tag for each entry
	int					checks = 0;
	int					errors = 0;
	int					test_num = 0;
	int					test_start_errors = 0;
	int					cycle_count = 0;

	mem_subsystem_top mem_subsystem_top_inst (.*);

	bind mem_stage mem_stage_props mem_stage_props_inst (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic is_misaligned(input mem_op_t op, input logic [31:0] addr);
		case (op)
		MEM_LH, MEM_LHU, MEM_SH:	return addr[0];
		MEM_LW, MEM_SW:				return addr[1:0] != 2'b00;
		default:					return 1'b0;
		endcase
	endfunction

	// read the whole word, shift the addressed byte down, then extend
	function automatic logic [31:0] predict_load(input mem_op_t op, input logic [31:0] addr);
		logic [31:0] word;
		word = '0;
		if (addr < `DMEM_WORDS * 4)
			word = {model_mem[{addr[9:2], 2'b11}], model_mem[{addr[9:2], 2'b10}],
				model_mem[{addr[9:2], 2'b01}], model_mem[{addr[9:2], 2'b00}]};
		word = word >> (8 * addr[1:0]);
		case (op)
		MEM_LB:		return {{24{word[7]}}, word[7:0]};
		MEM_LBU:	return {24'h000000, word[7:0]};
		MEM_LH:		return {{16{word[15]}}, word[15:0]};
		MEM_LHU:	return {16'h0000, word[15:0]};
		default:	return word;
		endcase
	endfunction

	task automatic apply_store(input mem_op_t op, input logic [31:0] addr, input logic [31:0] data);
		int nbytes;
		nbytes = (op == MEM_SB) ? 1 : (op == MEM_SH) ? 2 : 4;
		if (addr < `DMEM_WORDS * 4 && !is_misaligned(op, addr)) begin
			for (int i = 0; i < nbytes; i++)
				model_mem[addr[9:0] + i] = data[8*i +: 8];
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error %s: expected %08h, got %08h", name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// called on a rising edge
	task automatic drive_entry(input wb_src_t src, input mem_op_t op, input logic wena,
			input logic [31:0] data, input logic [31:0] sdata, input logic csr_w);
		pc_tag = pc_tag + 4;
		ir_sent[pc_tag[9:2]] = next_random();
		valid_in		<= 1'b1;
		flush_in		<= pc_tag[2];
		pc_ex			<= pc_tag;
		ir_ex			<= ir_sent[pc_tag[9:2]];
		rd_wena_ex		<= wena;
		rd_addr_ex		<= pc_tag[7:2];
		rd_data_ex		<= data;
		store_data_ex	<= sdata;
		wb_src_ex		<= src;
		mem_op_ex		<= op;
		csr_wena_ex		<= csr_w;
		csr_wdata_ex	<= ~data;
	endtask

	// returns on the rising edge that takes the entry
	task automatic wait_accept();
		do
			@(negedge clk);
		while (!ready_out);
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	task automatic expect_result(input logic [31:0] pc, input wb_src_t src, input logic wena,
			input logic csr_w, input logic [31:0] data, input logic data_known,
			input logic mal_l, input logic mal_s, input bus_resp_t rresp, input bus_resp_t bresp);
		while (!valid_out)
			@(negedge clk);
		compare_value("pc_mem", pc_mem, pc);
		compare_value("ir_mem", ir_mem, ir_sent[pc[9:2]]);
		compare_value("flush_out", flush_out, flush_in);
		compare_value("rd_addr_mem", rd_addr_mem, pc[7:2]);
		compare_value("wb_src_mem", wb_src_mem, src);
		compare_value("rd_wena_mem", rd_wena_mem, wena);
		compare_value("csr_wena_mem", csr_wena_mem, csr_w);
		compare_value("maligned_load_mem", maligned_load_mem, mal_l);
		compare_value("maligned_store_mem", maligned_store_mem, mal_s);
		compare_value("rresp_mem", rresp_mem, rresp);
		compare_value("bresp_mem", bresp_mem, bresp);
		if (data_known)
			compare_value("rd_data_mem", rd_data_mem, data);
		if (csr_w)
			compare_value("csr_wdata_mem", csr_wdata_mem, ~data);
		@(posedge clk);	// entry drains here
	endtask

	task automatic mem_access(input mem_op_t op, input logic [31:0] addr, input logic [31:0] sdata);
		logic			load;
		logic			in_range;
		logic	[31:0]	exp_data;
		load		= op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
		in_range	= addr < `DMEM_WORDS * 4;
		exp_data	= load ? predict_load(op, addr) : '0;
		drive_entry(SEL_MEM, op, load, addr, sdata, 1'b0);
		wait_accept();
		@(negedge clk);
		expect_result(pc_tag, SEL_MEM, load, 1'b0, exp_data, load,
			load && is_misaligned(op, addr), !load && is_misaligned(op, addr),
			(load && !in_range) ? RESP_SLVERR : RESP_OKAY,
			(!load && !in_range) ? RESP_SLVERR : RESP_OKAY);
		if (!load)
			apply_store(op, addr, sdata);
	endtask

	task automatic alu_entry(input logic [31:0] value);
		drive_entry(SEL_ALU, MEM_LW, 1'b1, value, '0, 1'b0);
		wait_accept();
		@(negedge clk);
		expect_result(pc_tag, SEL_ALU, 1'b1, 1'b0, value, 1'b1, 1'b0, 1'b0, RESP_OKAY, RESP_OKAY);
	endtask

	initial begin
		logic	[31:0]	addr_list [8];
		logic	[31:0]	base;
		logic	[31:0]	csr_pc;
		logic	[31:0]	csr_val;
		logic	[31:0]	alu_val;
		int				prop_fails;
		reset			<= 1'b1;
		valid_in		<= 1'b0;
		flush_in		<= 1'b0;
		ready_in		<= 1'b1;
		pc_ex			<= '0;
		ir_ex			<= '0;
		rd_wena_ex		<= 1'b0;
		rd_addr_ex		<= '0;
		rd_data_ex		<= '0;
		store_data_ex	<= '0;
		wb_src_ex		<= SEL_ALU;
		mem_op_ex		<= MEM_LB;
		csr_wena_ex		<= 1'b0;
		csr_wdata_ex	<= '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		compare_value("valid_out", valid_out, 1'b0);
		compare_value("pc_mem", pc_mem, '0);
		compare_value("ir_mem", ir_mem, '0);
		compare_value("rd_addr_mem", rd_addr_mem, '0);
		compare_value("rd_data_mem", rd_data_mem, '0);
		compare_value("csr_wdata_mem", csr_wdata_mem, '0);
		compare_value("wb_src_mem", wb_src_mem, '0);
		compare_value("rd_wena_mem/csr_wena_mem/maligned_load_mem/maligned_store_mem",
			{rd_wena_mem, csr_wena_mem, maligned_load_mem, maligned_store_mem}, '0);
		compare_value("rresp_mem/bresp_mem", {rresp_mem, bresp_mem}, '0);
		compare_value("flush_out", flush_out, 1'b0);
		compare_value("arvalid/awvalid/wvalid/rvalid/bvalid",
			{mem_subsystem_top_inst.arvalid, mem_subsystem_top_inst.awvalid,
			mem_subsystem_top_inst.wvalid, mem_subsystem_top_inst.rvalid,
			mem_subsystem_top_inst.bvalid}, '0);
		report_test("reset state");
		@(posedge clk);

		for (int i = 0; i < 8; i++) begin
			addr_list[i] = next_random() & 32'h0000_03fc;
			mem_access(MEM_SW, addr_list[i], next_random());
		end
		for (int i = 0; i < 8; i++)
			mem_access(MEM_LW, addr_list[i], '0);
		report_test("word store and load");

		for (int w = 0; w < 2; w++) begin
			base = next_random() & 32'h0000_03fc;
			mem_access(MEM_SW, base, next_random());
			for (int off = 0; off < 4; off++) begin
				mem_access(MEM_SB, base + off, next_random());
				mem_access(MEM_LB, base + off, '0);
				mem_access(MEM_LBU, base + off, '0);
			end
			for (int off = 0; off < 4; off += 2) begin
				mem_access(MEM_SH, base + off, next_random());
				mem_access(MEM_LH, base + off, '0);
				mem_access(MEM_LHU, base + off, '0);
			end
		end
		report_test("byte and halfword access");

		base = next_random() & 32'h0000_03fc;
		mem_access(MEM_SW, base, next_random());
		mem_access(MEM_LH, base + 1, '0);
		mem_access(MEM_LHU, base + 3, '0);
		mem_access(MEM_LW, base + 2, '0);
		mem_access(MEM_SH, base + 1, next_random());
		mem_access(MEM_SW, base + 3, next_random());
		mem_access(MEM_LW, base, '0);	// misaligned stores left it alone
		report_test("misaligned access");

		mem_access(MEM_LW, 32'h0000_0400, '0);
		base = 32'h0000_0400 | (next_random() & 32'h00ff_fffc);
		mem_access(MEM_SW, base, next_random());
		mem_access(MEM_LB, base + 1, '0);
		alu_entry(next_random());
		alu_entry(next_random());
		report_test("out of range and alu");

		// response held by the memory while ready_in is low
		base = addr_list[0];
		ready_in <= 1'b0;
		drive_entry(SEL_MEM, MEM_LW, 1'b1, base, '0, 1'b0);
		repeat (4) begin
			@(negedge clk);
			compare_value("ready_out", ready_out, 1'b0);
		end
		@(posedge clk);
		ready_in <= 1'b1;
		wait_accept();
		ready_in <= 1'b0;
		repeat (4) begin
			@(negedge clk);
			compare_value("valid_out", valid_out, 1'b1);
			compare_value("ready_out", ready_out, 1'b0);
			compare_value("rd_data_mem", rd_data_mem, predict_load(MEM_LW, base));
		end
		@(posedge clk);
		ready_in <= 1'b1;
		@(negedge clk);
		expect_result(pc_tag, SEL_MEM, 1'b1, 1'b0, predict_load(MEM_LW, base), 1'b1,
			1'b0, 1'b0, RESP_OKAY, RESP_OKAY);

		csr_val = next_random();
		drive_entry(SEL_CSR, MEM_LW, 1'b1, csr_val, '0, 1'b1);
		csr_pc = pc_tag;
		wait_accept();
		alu_val = next_random();
		drive_entry(SEL_ALU, MEM_LW, 1'b1, alu_val, '0, 1'b0);
		@(negedge clk);
		compare_value("ready_out", ready_out, 1'b0);	// blocked behind the csr write
		expect_result(csr_pc, SEL_CSR, 1'b1, 1'b1, csr_val, 1'b1, 1'b0, 1'b0,
			RESP_OKAY, RESP_OKAY);
		wait_accept();
		@(negedge clk);
		expect_result(pc_tag, SEL_ALU, 1'b1, 1'b0, alu_val, 1'b1, 1'b0, 1'b0,
			RESP_OKAY, RESP_OKAY);
		report_test("stall and ordering");

		prop_fails = mem_subsystem_top_inst.mem_stage_inst.mem_stage_props_inst.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
src/cpu_pipe_pkg.sv
src/dmem_bus_pkg.sv
src/dmem_request.sv
src/dmem_ram.sv
src/mem_stage.sv
src/mem_subsystem_top.sv
verif/mem_stage_props.sv
verif/mem_subsystem_tb.sv

// File: Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - src/cpu_pipe_pkg.sv
  - src/dmem_bus_pkg.sv
  - src/dmem_request.sv
  - src/dmem_ram.sv
  - src/mem_stage.sv
  - src/mem_subsystem_top.sv
  - target: test
    files:
      - verif/mem_stage_props.sv
      - verif/mem_subsystem_tb.sv
